// ==== design/bucket_filter_pkg.sv ====
// ==============================
// Bucket filter package
// Filter sizes, index and value types, and the state
// of the self-clearing bucket memories
// ==============================

package bucket_filter_pkg;

    // ==============================
    // Sizes
    // ==============================

    // Buckets in the whole filter and the width of each one
    localparam int N_BUCKETS = 16;
    localparam int BITS_PER_BUCKET = 4;

    // Banks are a power of two, picked by the low bits of a bucket index
    localparam int N_BANKS_RADIX = 1;
    localparam int N_BANKS = 1 << N_BANKS_RADIX;
    localparam int N_BANK_BUCKETS = N_BUCKETS >> N_BANKS_RADIX;

    // Pending removes waiting for a free update slot
    localparam int REMOVE_QUEUE_DEPTH = 8;

    // ==============================
    // Types
    // ==============================

    typedef logic [$clog2(N_BUCKETS)-1:0] bucket_idx_t;
    typedef logic [BITS_PER_BUCKET-1:0] bucket_val_t;

    // A global index splits as {bank_bucket_idx_t, bank_idx_t}
    typedef logic [N_BANKS_RADIX-1:0] bank_idx_t;
    typedef logic [$clog2(N_BANK_BUCKETS)-1:0] bank_bucket_idx_t;

    // Memories sweep zeros into every entry before they report ready
    typedef enum logic {RAM_CLEARING, RAM_READY} ram_state_t;

endpackage

// ==== design/bucket_ram.sv ====
// ==============================
// Bucket memory
// Simple dual-port memory that writes zeros to every entry
// after reset, with registered read address and read data
// ==============================

`timescale 1ns/1ns

module bucket_ram
    import bucket_filter_pkg::*;
#(
    parameter int DATA_BITS = BITS_PER_BUCKET
)
(
    input  logic                 clk,
    input  logic                 reset,
    output logic                 rdy,
    input  logic                 wen,
    input  bank_bucket_idx_t     waddr,
    input  logic [DATA_BITS-1:0] wdata,
    input  bank_bucket_idx_t     raddr,
    output logic [DATA_BITS-1:0] rdata
);

    logic [DATA_BITS-1:0] mem [N_BANK_BUCKETS];
    ram_state_t           state;
    bank_bucket_idx_t     sweep_idx;
    bank_bucket_idx_t     raddr_q;

    // One entry is cleared per cycle, so rdy stays low for N_BANK_BUCKETS cycles
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state     <= RAM_CLEARING;
            sweep_idx <= '0;
        end
        else if (state == RAM_CLEARING)
        begin
            sweep_idx <= sweep_idx + 1'b1;
            if (sweep_idx == bank_bucket_idx_t'(N_BANK_BUCKETS - 1))
            begin
                state <= RAM_READY;
            end
        end
    end

    assign rdy = (state == RAM_READY);

    // The sweep owns the write port until the memory is ready
    always_ff @(posedge clk)
    begin
        if (state == RAM_CLEARING)
        begin
            mem[sweep_idx] <= '0;
        end
        else if (wen)
        begin
            mem[waddr] <= wdata;
        end
    end

    // Two-cycle read; a write on the same edge as the data register is not seen
    always_ff @(posedge clk)
    begin
        raddr_q <= raddr;
        rdata   <= mem[raddr_q];
    end

endmodule

// ==== design/remove_queue.sv ====
// ==============================
// Remove queue
// Circular FIFO holding remove requests until an update
// slot in the target bank is free
// ==============================

`timescale 1ns/1ns

module remove_queue
    import bucket_filter_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        enq_en,
    input  bucket_idx_t enq_idx,
    input  bucket_val_t enq_mask,
    output logic        not_full,
    output logic        not_empty,
    output bucket_idx_t first_idx,
    output bucket_val_t first_mask,
    input  logic        deq_en
);

    typedef logic [$clog2(REMOVE_QUEUE_DEPTH)-1:0] ptr_t;
    typedef logic [$clog2(REMOVE_QUEUE_DEPTH+1)-1:0] count_t;

    bucket_idx_t idx_mem  [REMOVE_QUEUE_DEPTH];
    bucket_val_t mask_mem [REMOVE_QUEUE_DEPTH];
    ptr_t        wr_ptr;
    ptr_t        rd_ptr;
    count_t      count;
    logic        do_enq;
    logic        do_deq;

    assign not_full  = (count != count_t'(REMOVE_QUEUE_DEPTH));
    assign not_empty = (count != '0);
    assign do_enq    = enq_en && not_full;
    assign do_deq    = deq_en && not_empty;

    // Oldest entry is always on display
    assign first_idx  = idx_mem[rd_ptr];
    assign first_mask = mask_mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (do_enq)
        begin
            idx_mem[wr_ptr]  <= enq_idx;
            mask_mem[wr_ptr] <= enq_mask;
        end
    end

    // Depth is a power of two, so the pointers wrap on their own
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_enq)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_deq)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Simultaneous enqueue and dequeue leave the count alone
            if (do_enq && !do_deq)
            begin
                count <= count + 1'b1;
            end
            else if (do_deq && !do_enq)
            begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// ==== design/update_dispatch.sv ====
// ==============================
// Update dispatcher
// Queues removes, lets inserts win their bank, and routes
// updates and lookups to the banks by the low index bit
// ==============================

`timescale 1ns/1ns

module update_dispatch
    import bucket_filter_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    input  logic               insert_en,
    input  logic               remove_en,
    input  bucket_idx_t        insert_idx,
    input  bucket_idx_t        remove_idx,
    input  bucket_val_t        insert_mask,
    input  bucket_val_t        remove_mask,
    output logic               remove_not_full,
    input  bucket_idx_t        test_value_req,
    input  bucket_idx_t        test_iszero_req,
    output logic [N_BANKS-1:0] bank_insert_en,
    output logic [N_BANKS-1:0] bank_remove_en,
    output bank_bucket_idx_t   bank_insert_idx,
    output bank_bucket_idx_t   bank_remove_idx,
    output bucket_val_t        bank_insert_mask,
    output bucket_val_t        bank_remove_mask,
    output bank_bucket_idx_t   bank_value_idx,
    output bank_bucket_idx_t   bank_iszero_idx,
    output bank_idx_t          value_bank,
    output bank_idx_t          iszero_bank
);

    bucket_idx_t first_idx;
    bucket_val_t first_mask;
    bank_idx_t   insert_bank;
    bank_idx_t   remove_bank;
    logic        remove_pending;
    logic        process_remove;

    remove_queue u_remove_queue
    (
        .clk        (clk),
        .reset      (reset),
        .enq_en     (remove_en),
        .enq_idx    (remove_idx),
        .enq_mask   (remove_mask),
        .not_full   (remove_not_full),
        .not_empty  (remove_pending),
        .first_idx  (first_idx),
        .first_mask (first_mask),
        .deq_en     (process_remove)
    );

    // Bank number is the low part of the index
    assign insert_bank = bank_idx_t'(insert_idx);
    assign remove_bank = bank_idx_t'(first_idx);
    assign value_bank  = bank_idx_t'(test_value_req);
    assign iszero_bank = bank_idx_t'(test_iszero_req);

    // Local index is what is left after the bank bits
    assign bank_insert_idx = bank_bucket_idx_t'(insert_idx >> N_BANKS_RADIX);
    assign bank_remove_idx = bank_bucket_idx_t'(first_idx >> N_BANKS_RADIX);
    assign bank_value_idx  = bank_bucket_idx_t'(test_value_req >> N_BANKS_RADIX);
    assign bank_iszero_idx = bank_bucket_idx_t'(test_iszero_req >> N_BANKS_RADIX);

    assign bank_insert_mask = insert_mask;
    assign bank_remove_mask = first_mask;

    // Oldest remove goes whenever its bank has no insert this cycle
    assign process_remove = remove_pending && !(insert_en && (insert_bank == remove_bank));

    always_comb
    begin
        for (int b = 0; b < N_BANKS; b++)
        begin
            bank_insert_en[b] = insert_en && (insert_bank == bank_idx_t'(b));
            bank_remove_en[b] = process_remove && (remove_bank == bank_idx_t'(b));
        end
    end

endmodule

// ==== design/filter_bank.sv ====
// ==============================
// Filter bank
// Read-modify-write update pipeline over one slice of the
// buckets, with bypassed value and is-zero lookup ports
// ==============================

`timescale 1ns/1ns

module filter_bank
    import bucket_filter_pkg::*;
(
    input  logic             clk,
    input  logic             reset,
    output logic             rdy,
    input  logic             insert_en,
    input  logic             remove_en,
    input  bank_bucket_idx_t insert_idx,
    input  bank_bucket_idx_t remove_idx,
    input  bucket_val_t      insert_mask,
    input  bucket_val_t      remove_mask,
    input  bank_bucket_idx_t value_idx,
    input  bank_bucket_idx_t iszero_idx,
    output bucket_val_t      value,
    output logic             iszero
);

    // ==============================
    // Update pipeline
    // ==============================

    // Stage 0 is the incoming request, stage 1 waits on the read address,
    // stage 2 has the memory data and writes on the following edge
    logic             upd_en  [0:2];
    bank_bucket_idx_t upd_idx [0:2];
    bucket_val_t      upd_set [0:2];
    bucket_val_t      upd_clr [0:2];
    bucket_val_t      upd_rd_val;
    bucket_val_t      merge_set;
    bucket_val_t      merge_clr;
    logic             wr_en;
    bank_bucket_idx_t wr_idx;
    bucket_val_t      wr_val;
    logic             wr_nonzero;

    // The dispatcher never raises both enables for different buckets
    always_comb
    begin
        upd_en[0]  = insert_en || remove_en;
        upd_idx[0] = insert_en ? insert_idx : remove_idx;
        upd_set[0] = insert_en ? insert_mask : '0;
        upd_clr[0] = remove_en ? remove_mask : '0;
    end

    // The update one stage ahead writes on the same edge our memory read
    // lands, so its masks are folded in here. Removes are applied before
    // inserts, which is why a remove may not closely follow an insert
    always_comb
    begin
        merge_set = upd_set[1];
        merge_clr = upd_clr[1];
        if (upd_en[2] && (upd_idx[2] == upd_idx[1]))
        begin
            merge_set = merge_set | upd_set[2];
            merge_clr = merge_clr | upd_clr[2];
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            upd_en[1] <= 1'b0;
            upd_en[2] <= 1'b0;
        end
        else
        begin
            upd_en[1] <= upd_en[0];
            upd_en[2] <= upd_en[1];
        end
        upd_idx[1] <= upd_idx[0];
        upd_idx[2] <= upd_idx[1];
        upd_set[1] <= upd_set[0];
        upd_clr[1] <= upd_clr[0];
        upd_set[2] <= merge_set;
        upd_clr[2] <= merge_clr;
    end

    // The same write goes to all three memories
    assign wr_en      = upd_en[2];
    assign wr_idx     = upd_idx[2];
    assign wr_val     = (upd_rd_val & ~upd_clr[2]) | upd_set[2];
    assign wr_nonzero = |wr_val;

    // This memory clears at the same rate as the others, so it speaks for all
    bucket_ram #(.DATA_BITS(BITS_PER_BUCKET)) u_mem_upd
    (
        .clk   (clk),
        .reset (reset),
        .rdy   (rdy),
        .wen   (wr_en),
        .waddr (wr_idx),
        .wdata (wr_val),
        .raddr (upd_idx[0]),
        .rdata (upd_rd_val)
    );

    // ==============================
    // Lookup ports
    // ==============================

    // A lookup's memory read misses only the write landing on the same edge,
    // so one bypass register catches it. Later updates stay invisible
    bank_bucket_idx_t val_idx_q;
    logic             val_byp_en;
    bucket_val_t      val_byp;
    bucket_val_t      val_rd;
    bank_bucket_idx_t iz_idx_q;
    logic             iz_byp_en;
    logic             iz_byp;
    logic             iz_rd;

    always_ff @(posedge clk)
    begin
        val_idx_q <= value_idx;
        iz_idx_q  <= iszero_idx;
        val_byp   <= wr_val;
        iz_byp    <= wr_nonzero;
        if (reset)
        begin
            val_byp_en <= 1'b0;
            iz_byp_en  <= 1'b0;
        end
        else
        begin
            val_byp_en <= wr_en && (wr_idx == val_idx_q);
            iz_byp_en  <= wr_en && (wr_idx == iz_idx_q);
        end
    end

    bucket_ram #(.DATA_BITS(BITS_PER_BUCKET)) u_mem_value
    (
        .clk   (clk),
        .reset (reset),
        .rdy   (),
        .wen   (wr_en),
        .waddr (wr_idx),
        .wdata (wr_val),
        .raddr (value_idx),
        .rdata (val_rd)
    );

    // Stores whether the bucket holds any set bit
    bucket_ram #(.DATA_BITS(1)) u_mem_zero
    (
        .clk   (clk),
        .reset (reset),
        .rdy   (),
        .wen   (wr_en),
        .waddr (wr_idx),
        .wdata (wr_nonzero),
        .raddr (iszero_idx),
        .rdata (iz_rd)
    );

    assign value  = val_byp_en ? val_byp : val_rd;
    assign iszero = ~(iz_byp_en ? iz_byp : iz_rd);

endmodule

// ==== design/result_select.sv ====
// ==============================
// Result selector
// Follows each lookup's bank down the read pipeline and
// registers that bank's answer onto the outputs
// ==============================

`timescale 1ns/1ns

module result_select
    import bucket_filter_pkg::*;
(
    input  logic                      clk,
    input  bank_idx_t                 value_bank,
    input  bank_idx_t                 iszero_bank,
    input  bucket_val_t [N_BANKS-1:0] bank_value,
    input  logic        [N_BANKS-1:0] bank_iszero,
    output bucket_val_t               test_value,
    output logic                      test_iszero
);

    bank_idx_t value_bank_d1;
    bank_idx_t value_bank_d2;
    bank_idx_t iszero_bank_d1;
    bank_idx_t iszero_bank_d2;

    // Two delays match the two-cycle memory read inside each bank
    always_ff @(posedge clk)
    begin
        value_bank_d1  <= value_bank;
        value_bank_d2  <= value_bank_d1;
        iszero_bank_d1 <= iszero_bank;
        iszero_bank_d2 <= iszero_bank_d1;
    end

    // Third cycle of lookup latency
    always_ff @(posedge clk)
    begin
        test_value  <= bank_value[value_bank_d2];
        test_iszero <= bank_iszero[iszero_bank_d2];
    end

endmodule

// ==== design/bucket_filter_top.sv ====
// ==============================
// Banked bucket filter
// Dispatcher, array of filter banks and result selector.
// Lookups return three cycles after they are sampled
// ==============================

`timescale 1ns/1ns

module bucket_filter_top
    import bucket_filter_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    output logic        rdy,
    input  bucket_idx_t test_value_req,
    input  bucket_idx_t test_iszero_req,
    input  logic        insert_en,
    input  bucket_idx_t insert_idx,
    input  bucket_val_t insert_mask,
    input  logic        remove_en,
    input  bucket_idx_t remove_idx,
    input  bucket_val_t remove_mask,
    output logic        remove_not_full,
    output bucket_val_t test_value,
    output logic        test_iszero
);

    logic        [N_BANKS-1:0] bank_insert_en;
    logic        [N_BANKS-1:0] bank_remove_en;
    logic        [N_BANKS-1:0] bank_rdy;
    bucket_val_t [N_BANKS-1:0] bank_value;
    logic        [N_BANKS-1:0] bank_iszero;
    bank_bucket_idx_t          bank_insert_idx;
    bank_bucket_idx_t          bank_remove_idx;
    bucket_val_t               bank_insert_mask;
    bucket_val_t               bank_remove_mask;
    bank_bucket_idx_t          bank_value_idx;
    bank_bucket_idx_t          bank_iszero_idx;
    bank_idx_t                 value_bank;
    bank_idx_t                 iszero_bank;

    update_dispatch u_dispatch
    (
        .clk              (clk),
        .reset            (reset),
        .insert_en        (insert_en),
        .remove_en        (remove_en),
        .insert_idx       (insert_idx),
        .remove_idx       (remove_idx),
        .insert_mask      (insert_mask),
        .remove_mask      (remove_mask),
        .remove_not_full  (remove_not_full),
        .test_value_req   (test_value_req),
        .test_iszero_req  (test_iszero_req),
        .bank_insert_en   (bank_insert_en),
        .bank_remove_en   (bank_remove_en),
        .bank_insert_idx  (bank_insert_idx),
        .bank_remove_idx  (bank_remove_idx),
        .bank_insert_mask (bank_insert_mask),
        .bank_remove_mask (bank_remove_mask),
        .bank_value_idx   (bank_value_idx),
        .bank_iszero_idx  (bank_iszero_idx),
        .value_bank       (value_bank),
        .iszero_bank      (iszero_bank)
    );

    // Every bank sees the same indexes and masks, only its enables differ
    for (genvar b = 0; b < N_BANKS; b++)
    begin : g_bank
        filter_bank u_bank
        (
            .clk         (clk),
            .reset       (reset),
            .rdy         (bank_rdy[b]),
            .insert_en   (bank_insert_en[b]),
            .remove_en   (bank_remove_en[b]),
            .insert_idx  (bank_insert_idx),
            .remove_idx  (bank_remove_idx),
            .insert_mask (bank_insert_mask),
            .remove_mask (bank_remove_mask),
            .value_idx   (bank_value_idx),
            .iszero_idx  (bank_iszero_idx),
            .value       (bank_value[b]),
            .iszero      (bank_iszero[b])
        );
    end

    // All banks clear in lockstep
    assign rdy = bank_rdy[0];

    result_select u_select
    (
        .clk         (clk),
        .value_bank  (value_bank),
        .iszero_bank (iszero_bank),
        .bank_value  (bank_value),
        .bank_iszero (bank_iszero),
        .test_value  (test_value),
        .test_iszero (test_iszero)
    );

endmodule

// ==== verif/bucket_filter_tb.sv ====
// ==============================
// Bucket filter testbench
// Table-driven stimulus with a reference model of the
// buckets and fixed three-cycle lookup sampling
// ==============================

`timescale 1ns/1ns

module bucket_filter_tb
    import bucket_filter_pkg::*;
();

    typedef enum logic [2:0]
    {
        OP_INSERT,
        OP_REMOVE,
        OP_BOTH,
        OP_TEST,
        OP_MODEL_TEST,
        OP_IDLE,
        OP_FULL_CHECK
    } op_t;

    // idx2 and mask2 carry the remove of an OP_BOTH step.
    // In a model test idx2 is the bucket asked of the is-zero client
    typedef struct packed
    {
        op_t         op;
        bucket_idx_t idx;
        bucket_val_t mask;
        bucket_idx_t idx2;
        bucket_val_t mask2;
        bucket_val_t exp_val;
        logic        exp_flag;
        int          cycles;
    } step_t;

    logic        clk;
    logic        reset;
    logic        rdy;
    bucket_idx_t test_value_req;
    bucket_idx_t test_iszero_req;
    logic        insert_en;
    bucket_idx_t insert_idx;
    bucket_val_t insert_mask;
    logic        remove_en;
    bucket_idx_t remove_idx;
    bucket_val_t remove_mask;
    logic        remove_not_full;
    bucket_val_t test_value;
    logic        test_iszero;

    step_t       steps [$];
    bucket_val_t model [N_BUCKETS];
    int          est_cycles = 0;
    int          cycle_limit = 0;
    int          cycle_count = 0;
    int          errors = 0;
    int          checks = 0;
    int          rdy_wait = 0;

    bucket_filter_top u_dut
    (
        .clk             (clk),
        .reset           (reset),
        .rdy             (rdy),
        .test_value_req  (test_value_req),
        .test_iszero_req (test_iszero_req),
        .insert_en       (insert_en),
        .insert_idx      (insert_idx),
        .insert_mask     (insert_mask),
        .remove_en       (remove_en),
        .remove_idx      (remove_idx),
        .remove_mask     (remove_mask),
        .remove_not_full (remove_not_full),
        .test_value      (test_value),
        .test_iszero     (test_iszero)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // The watchdog limit is set once the table is built
    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit)
        begin
            $display("Timeout after %0d cycles, the table did not complete", cycle_count);
            $display("Finished with errors");
            $finish;
        end
    end

    // ==============================
    // Table building
    // ==============================

    // Each step also adds the cycles it is expected to take
    function automatic void append_step(op_t op, bucket_idx_t idx, bucket_val_t mask,
                                        bucket_idx_t idx2, bucket_val_t mask2,
                                        bucket_val_t exp_val, logic exp_flag, int cycles);
        step_t s;
        s = '{op, idx, mask, idx2, mask2, exp_val, exp_flag, cycles};
        steps.push_back(s);
        if (op == OP_IDLE)
            est_cycles += cycles;
        else if (op == OP_TEST || op == OP_MODEL_TEST)
            est_cycles += 4;
        else
            est_cycles += 1;
    endfunction

    task automatic build_table();
        int          kind;
        int          last_ins [N_BUCKETS];
        logic        rem_pending;
        int          rem_run;
        bucket_idx_t idx;
        bucket_idx_t idx2;
        bucket_val_t mask;
        rem_pending = 1'b0;
        rem_run = 0;
        foreach (last_ins[b])
            last_ins[b] = -100;

        // Queue starts empty, then every bucket reads back as cleared
        append_step(OP_FULL_CHECK, '0, '0, '0, '0, '0, 1'b1, 0);
        for (int b = 0; b < N_BUCKETS; b++)
            append_step(OP_TEST, bucket_idx_t'(b), '0, '0, '0, 4'h0, 1'b1, 0);

        // Lookups the cycle after an insert go through the bypass
        append_step(OP_INSERT, 4'd3, 4'h5, '0, '0, '0, 1'b0, 0);
        append_step(OP_TEST, 4'd3, '0, '0, '0, 4'h5, 1'b0, 0);
        append_step(OP_INSERT, 4'd4, 4'h1, '0, '0, '0, 1'b0, 0);
        append_step(OP_INSERT, 4'd4, 4'h2, '0, '0, '0, 1'b0, 0);
        append_step(OP_INSERT, 4'd4, 4'h8, '0, '0, '0, 1'b0, 0);
        append_step(OP_TEST, 4'd4, '0, '0, '0, 4'hb, 1'b0, 0);
        append_step(OP_INSERT, 4'd9, 4'h6, '0, '0, '0, 1'b0, 0);
        append_step(OP_INSERT, 4'd8, 4'h3, '0, '0, '0, 1'b0, 0);
        append_step(OP_TEST, 4'd9, '0, '0, '0, 4'h6, 1'b0, 0);
        append_step(OP_TEST, 4'd8, '0, '0, '0, 4'h3, 1'b0, 0);
        append_step(OP_INSERT, 4'd3, 4'h8, '0, '0, '0, 1'b0, 0);
        append_step(OP_TEST, 4'd3, '0, '0, '0, 4'hd, 1'b0, 0);
        append_step(OP_INSERT, 4'd10, 4'h4, '0, '0, '0, 1'b0, 0);
        append_step(OP_TEST, 4'd10, '0, '0, '0, 4'h4, 1'b0, 0);

        // Removes clear only their own bits once the queue has drained
        append_step(OP_REMOVE, 4'd4, 4'h2, '0, '0, '0, 1'b0, 0);
        append_step(OP_IDLE, '0, '0, '0, '0, '0, 1'b0, 8);
        append_step(OP_TEST, 4'd4, '0, '0, '0, 4'h9, 1'b0, 0);
        append_step(OP_REMOVE, 4'd3, 4'h5, '0, '0, '0, 1'b0, 0);
        append_step(OP_REMOVE, 4'd9, 4'h6, '0, '0, '0, 1'b0, 0);
        append_step(OP_IDLE, '0, '0, '0, '0, '0, 1'b0, 8);
        append_step(OP_TEST, 4'd3, '0, '0, '0, 4'h8, 1'b0, 0);
        append_step(OP_TEST, 4'd9, '0, '0, '0, 4'h0, 1'b1, 0);
        append_step(OP_REMOVE, 4'd4, 4'hf, '0, '0, '0, 1'b0, 0);
        append_step(OP_IDLE, '0, '0, '0, '0, '0, 1'b0, 8);
        append_step(OP_TEST, 4'd4, '0, '0, '0, 4'h0, 1'b1, 0);

        // ==============================
        // Bank 0 starvation
        // ==============================

        append_step(OP_INSERT, 4'd12, 4'hf, '0, '0, '0, 1'b0, 0);
        append_step(OP_INSERT, 4'd14, 4'hf, '0, '0, '0, 1'b0, 0);
        append_step(OP_TEST, 4'd12, '0, '0, '0, 4'hf, 1'b0, 0);
        // Inserts hold bank 0 every cycle, so all eight removes stay queued
        append_step(OP_BOTH, 4'd0, 4'h1, 4'd12, 4'h1, '0, 1'b0, 0);
        append_step(OP_BOTH, 4'd2, 4'h2, 4'd14, 4'h1, '0, 1'b0, 0);
        append_step(OP_BOTH, 4'd6, 4'h4, 4'd12, 4'h2, '0, 1'b0, 0);
        append_step(OP_BOTH, 4'd0, 4'h8, 4'd14, 4'h2, '0, 1'b0, 0);
        append_step(OP_BOTH, 4'd2, 4'h1, 4'd12, 4'h4, '0, 1'b0, 0);
        append_step(OP_BOTH, 4'd6, 4'h2, 4'd14, 4'h4, '0, 1'b0, 0);
        append_step(OP_BOTH, 4'd0, 4'h4, 4'd12, 4'h8, '0, 1'b0, 0);
        append_step(OP_BOTH, 4'd2, 4'h8, 4'd14, 4'h2, '0, 1'b0, 0);
        append_step(OP_FULL_CHECK, '0, '0, '0, '0, '0, 1'b0, 0);
        append_step(OP_IDLE, '0, '0, '0, '0, '0, 1'b0, 12);
        append_step(OP_FULL_CHECK, '0, '0, '0, '0, '0, 1'b1, 0);
        append_step(OP_TEST, 4'd0, '0, '0, '0, 4'hd, 1'b0, 0);
        append_step(OP_TEST, 4'd2, '0, '0, '0, 4'hb, 1'b0, 0);
        append_step(OP_TEST, 4'd6, '0, '0, '0, 4'h6, 1'b0, 0);
        append_step(OP_TEST, 4'd12, '0, '0, '0, 4'h0, 1'b1, 0);
        append_step(OP_TEST, 4'd14, '0, '0, '0, 4'h8, 1'b0, 0);
        append_step(OP_TEST, 4'd8, '0, '0, '0, 4'h3, 1'b0, 0);

        // ==============================
        // Random section
        // ==============================

        // Removes drain before any later insert or test, and never chase
        // a recent insert to their bucket
        for (int i = 0; i < 40; i++)
        begin
            kind = $urandom % 3;
            idx  = bucket_idx_t'($urandom % N_BUCKETS);
            mask = bucket_val_t'($urandom % (1 << BITS_PER_BUCKET));
            if (kind != 1 && rem_pending)
            begin
                append_step(OP_IDLE, '0, '0, '0, '0, '0, 1'b0, 8);
                rem_pending = 1'b0;
                rem_run = 0;
            end
            if (kind == 0)
            begin
                last_ins[idx] = est_cycles;
                append_step(OP_INSERT, idx, mask, '0, '0, '0, 1'b0, 0);
            end
            else if (kind == 1)
            begin
                if (rem_run == REMOVE_QUEUE_DEPTH)
                begin
                    append_step(OP_IDLE, '0, '0, '0, '0, '0, 1'b0, 8);
                    rem_run = 0;
                end
                if (est_cycles - last_ins[idx] < 5)
                    append_step(OP_IDLE, '0, '0, '0, '0, '0, 1'b0, 5);
                append_step(OP_REMOVE, idx, mask, '0, '0, '0, 1'b0, 0);
                rem_pending = 1'b1;
                rem_run++;
            end
            else
            begin
                // The two lookup clients ask about unrelated buckets
                idx2 = bucket_idx_t'($urandom % N_BUCKETS);
                append_step(OP_MODEL_TEST, idx, '0, idx2, '0, '0, 1'b0, 0);
            end
        end
    endtask

    // ==============================
    // Step application
    // ==============================

    // Inputs change 1 ns after the edge and enables last one cycle
    task automatic next_cycle();
        @(posedge clk);
        #1;
        insert_en = 1'b0;
        remove_en = 1'b0;
    endtask

    task automatic run_lookup(input bucket_idx_t value_idx, input bucket_idx_t zero_idx,
                              input bucket_val_t exp_val, input logic exp_zero);
        next_cycle();
        test_value_req  = value_idx;
        test_iszero_req = zero_idx;
        // Result sits on the outputs after the third edge from here
        repeat (3) next_cycle();
        checks += 2;
        assert (test_value == exp_val)
        else
        begin
            $display("Mismatch test_value bucket 0x%h: got 0x%h, expected 0x%h",
                     value_idx, test_value, exp_val);
            errors++;
        end
        assert (test_iszero == exp_zero)
        else
        begin
            $display("Mismatch test_iszero bucket 0x%h: got 0x%h, expected 0x%h",
                     zero_idx, test_iszero, exp_zero);
            errors++;
        end
    endtask

    task automatic apply_step(input step_t s);
        case (s.op)
            OP_INSERT:
            begin
                next_cycle();
                insert_en   = 1'b1;
                insert_idx  = s.idx;
                insert_mask = s.mask;
                model[s.idx] = model[s.idx] | s.mask;
            end
            OP_REMOVE, OP_BOTH:
            begin
                next_cycle();
                while (!remove_not_full)
                    next_cycle();
                remove_en = 1'b1;
                if (s.op == OP_BOTH)
                begin
                    insert_en   = 1'b1;
                    insert_idx  = s.idx;
                    insert_mask = s.mask;
                    remove_idx  = s.idx2;
                    remove_mask = s.mask2;
                    model[s.idx] = model[s.idx] | s.mask;
                end
                else
                begin
                    remove_idx  = s.idx;
                    remove_mask = s.mask;
                end
                model[remove_idx] = model[remove_idx] & ~remove_mask;
            end
            OP_TEST:
                run_lookup(s.idx, s.idx, s.exp_val, s.exp_flag);
            OP_MODEL_TEST:
                run_lookup(s.idx, s.idx2, model[s.idx], model[s.idx2] == '0);
            OP_IDLE:
                repeat (s.cycles) next_cycle();
            OP_FULL_CHECK:
            begin
                next_cycle();
                checks++;
                assert (remove_not_full == s.exp_flag)
                else
                begin
                    $display("Mismatch remove_not_full: got 0x%h, expected 0x%h",
                             remove_not_full, s.exp_flag);
                    errors++;
                end
            end
            default:
                next_cycle();
        endcase
    endtask

    initial
    begin
        void'($urandom(32'h4517));
        reset           = 1'b1;
        insert_en       = 1'b0;
        insert_idx      = '0;
        insert_mask     = '0;
        remove_en       = 1'b0;
        remove_idx      = '0;
        remove_mask     = '0;
        test_value_req  = '0;
        test_iszero_req = '0;
        foreach (model[b])
            model[b] = '0;

        build_table();
        cycle_limit = est_cycles + 200;

        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        // Memories sweep zeros in, one entry per cycle, before rdy goes high
        while (!rdy)
        begin
            next_cycle();
            rdy_wait++;
        end
        checks++;
        assert (rdy_wait == N_BANK_BUCKETS)
        else
        begin
            $display("Mismatch rdy low cycles: got 0x%h, expected 0x%h",
                     rdy_wait, N_BANK_BUCKETS);
            errors++;
        end

        for (int i = 0; i < steps.size(); i++)
            apply_step(steps[i]);
        repeat (2) next_cycle();

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

// ==== compile.f ====
design/bucket_filter_pkg.sv
design/bucket_ram.sv
design/remove_queue.sv
design/update_dispatch.sv
design/filter_bank.sv
design/result_select.sv
design/bucket_filter_top.sv
verif/bucket_filter_tb.sv

// ==== Makefile ====
# Verilator flow for the banked bucket filter

TB_TOP = bucket_filter_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f compile.f --top-module bucket_filter_top

# The run passes only when the testbench prints its pass line
sim:
	verilator --binary --timing --assert -f compile.f --top-module $(TB_TOP) -Mdir obj_dir
	./obj_dir/V$(TB_TOP) | tee /dev/stderr | grep -q "^Finished with no errors$$"

clean:
	rm -rf obj_dir
